/* src.f */
rtl/mac_pkg.sv
rtl/mul_port_if.sv
rtl/cla_adder.sv
rtl/dadda_mul8.sv
rtl/mul_arbiter.sv
rtl/mac_lane.sv
rtl/mac_top.sv
test/tb_mac_top.sv

/* Makefile */
# Verilator build and run for the mac8 testbench.

VERILATOR ?= verilator
TOP       ?= tb_mac_top
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat src.f)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(VERILATOR), run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP LOG OBJ_DIR VFLAGS"

$(SIM_BIN): src.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f src.f

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_mac_top.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_mac_top;

    localparam int ACC_WIDTH      = 16;
    localparam int CLK_HALF       = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int NUM_FIXED      = 12;
    localparam int NUM_RANDOM     = 20;
    localparam int NUM_ROWS       = NUM_FIXED + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 8 + 50;

    typedef struct {
        logic             en0;
        mac_pkg::mac_op_e op0;
        logic [7:0]       a0;
        logic [7:0]       b0;
        logic             en1;
        mac_pkg::mac_op_e op1;
        logic [7:0]       a1;
        logic [7:0]       b1;
    } row_t;

    logic                 clk;
    logic                 reset;
    logic                 cmd0_valid;
    mac_pkg::mac_op_e     cmd0_op;
    logic [7:0]           cmd0_a;
    logic [7:0]           cmd0_b;
    logic                 busy0;
    logic                 done0;
    logic [ACC_WIDTH-1:0] result0;
    logic                 cmd1_valid;
    mac_pkg::mac_op_e     cmd1_op;
    logic [7:0]           cmd1_a;
    logic [7:0]           cmd1_b;
    logic                 busy1;
    logic                 done1;
    logic [ACC_WIDTH-1:0] result1;

    row_t                 rows [NUM_ROWS];
    logic [ACC_WIDTH-1:0] model_acc0;
    logic [ACC_WIDTH-1:0] model_acc1;
    logic                 model_last_lane1;
    logic                 quiet;
    integer               seed;
    int                   errors;
    int                   cycle_count;

    mac_top #(
        .ACC_WIDTH (ACC_WIDTH)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .cmd0_valid (cmd0_valid),
        .cmd0_op    (cmd0_op),
        .cmd0_a     (cmd0_a),
        .cmd0_b     (cmd0_b),
        .busy0      (busy0),
        .done0      (done0),
        .result0    (result0),
        .cmd1_valid (cmd1_valid),
        .cmd1_op    (cmd1_op),
        .cmd1_a     (cmd1_a),
        .cmd1_b     (cmd1_b),
        .busy1      (busy1),
        .done1      (done1),
        .result1    (result1)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("CHECK FAILED time %0t: %s expected 0x%0h, got 0x%0h",
                 $time, name, expected, actual);
    endtask

    // accumulator rule per opcode, wrapping at ACC_WIDTH.
    function automatic logic [ACC_WIDTH-1:0] next_acc(input mac_pkg::mac_op_e op,
            input logic [ACC_WIDTH-1:0] acc, input logic [7:0] a, input logic [7:0] b);
        logic [15:0] prod;
        prod = {8'd0, a} * {8'd0, b};
        case (op)
            mac_pkg::OP_MUL: return ACC_WIDTH'(prod);
            mac_pkg::OP_MAC: return acc + ACC_WIDTH'(prod);
            default: return '0;
        endcase
    endfunction

    task automatic set_row(input int idx, input logic en0, input mac_pkg::mac_op_e op0,
                           input logic [7:0] a0, input logic [7:0] b0, input logic en1,
                           input mac_pkg::mac_op_e op1, input logic [7:0] a1,
                           input logic [7:0] b1);
        rows[idx] = '{en0, op0, a0, b0, en1, op1, a1, b1};
    endtask

    task automatic fill_table();
        logic [31:0] rnd;
        set_row(0, 1, mac_pkg::OP_MUL, 8'd0, 8'd0, 1, mac_pkg::OP_MUL, 8'd1, 8'd1);
        set_row(1, 1, mac_pkg::OP_MUL, 8'd255, 8'd255, 0, mac_pkg::OP_MUL, 8'd0, 8'd0);
        set_row(2, 0, mac_pkg::OP_MUL, 8'd0, 8'd0, 1, mac_pkg::OP_MUL, 8'd255, 8'd1);
        set_row(3, 1, mac_pkg::OP_MAC, 8'd255, 8'd255, 1, mac_pkg::OP_MAC, 8'd255, 8'd255);
        set_row(4, 1, mac_pkg::OP_CLR, 8'd9, 8'd9, 1, mac_pkg::OP_MAC, 8'd2, 8'd3);
        set_row(5, 1, mac_pkg::OP_MAC, 8'd12, 8'd34, 1, mac_pkg::OP_CLR, 8'd0, 8'd0);
        set_row(6, 1, mac_pkg::OP_MAC, 8'd1, 8'd0, 1, mac_pkg::OP_MUL, 8'd128, 8'd2);
        set_row(7, 1, mac_pkg::OP_CLR, 8'd0, 8'd0, 1, mac_pkg::OP_CLR, 8'd0, 8'd0);
        set_row(8, 1, mac_pkg::OP_MAC, 8'd200, 8'd100, 1, mac_pkg::OP_MAC, 8'd255, 8'd255);
        set_row(9, 1, mac_pkg::OP_MAC, 8'd200, 8'd100, 1, mac_pkg::OP_MAC, 8'd255, 8'd255);
        set_row(10, 1, mac_pkg::OP_MAC, 8'd200, 8'd200, 0, mac_pkg::OP_MUL, 8'd0, 8'd0);
        set_row(11, 1, mac_pkg::OP_MUL, 8'd1, 8'd255, 1, mac_pkg::OP_MUL, 8'd170, 8'd85);
        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            rnd = $random(seed);
            rows[i].en0 = rnd[24];
            rows[i].op0 = mac_pkg::mac_op_e'(2'(rnd[23:16] % 8'd3));
            rows[i].a0  = rnd[7:0];
            rows[i].b0  = rnd[15:8];
            rnd = $random(seed);
            rows[i].en1 = rnd[24];
            rows[i].op1 = mac_pkg::mac_op_e'(2'(rnd[23:16] % 8'd3));
            rows[i].a1  = rnd[7:0];
            rows[i].b1  = rnd[15:8];
            // at least one lane works in every row.
            if (!rows[i].en0 && !rows[i].en1)
                rows[i].en0 = 1'b1;
        end
    endtask

    task automatic watch_lane(input int lane, input logic done, input logic busy,
                              input logic [ACC_WIDTH-1:0] result,
                              input logic [ACC_WIDTH-1:0] expected,
                              input int t, input int exp_lat, inout logic fin);
        string tag;
        tag = $sformatf("%0d", lane);
        if (fin) begin
            // finished or unused lane stays quiet and keeps its value.
            if (done !== 1'b0)
                report_mismatch({"done", tag}, 32'd0, 32'(done));
            if (busy !== 1'b0)
                report_mismatch({"busy", tag}, 32'd0, 32'(busy));
            if (result !== expected)
                report_mismatch({"result", tag}, 32'(expected), 32'(result));
        end else if (done === 1'b1) begin
            fin = 1'b1;
            if (busy !== 1'b1)
                report_mismatch({"busy", tag}, 32'd1, 32'(busy));
            if (result !== expected)
                report_mismatch({"result", tag}, 32'(expected), 32'(result));
            if (t != exp_lat)
                report_mismatch({"done", tag, " latency"}, 32'(exp_lat), 32'(t));
        end else if (busy !== 1'b1) begin
            report_mismatch({"busy", tag}, 32'd1, 32'(busy));
        end
    endtask

    task automatic run_row(input int idx);
        row_t r;
        logic mul0;
        logic mul1;
        int   exp_lat0;
        int   exp_lat1;
        int   t;
        logic fin0;
        logic fin1;
        r = rows[idx];
        mul0 = r.en0 && (r.op0 != mac_pkg::OP_CLR);
        mul1 = r.en1 && (r.op1 != mac_pkg::OP_CLR);
        exp_lat0 = mul0 ? 3 : 1;
        exp_lat1 = mul1 ? 3 : 1;
        // on contention the lane not served last goes first, the other waits a cycle.
        if (mul0 && mul1) begin
            if (model_last_lane1)
                exp_lat1 = 4;
            else
                exp_lat0 = 4;
        end else if (mul0 || mul1) begin
            model_last_lane1 = mul1;
        end
        if (r.en0)
            model_acc0 = next_acc(r.op0, model_acc0, r.a0, r.b0);
        if (r.en1)
            model_acc1 = next_acc(r.op1, model_acc1, r.a1, r.b1);
        @(posedge clk);
        #DRIVE_DELAY;
        cmd0_valid = r.en0;
        cmd0_op    = r.op0;
        cmd0_a     = r.a0;
        cmd0_b     = r.b0;
        cmd1_valid = r.en1;
        cmd1_op    = r.op1;
        cmd1_a     = r.a1;
        cmd1_b     = r.b1;
        fin0 = !r.en0;
        fin1 = !r.en1;
        t = 0;
        while (!(fin0 && fin1)) begin
            @(posedge clk);
            #DRIVE_DELAY;
            t++;
            cmd0_valid = 1'b0;
            cmd1_valid = 1'b0;
            watch_lane(0, done0, busy0, result0, model_acc0, t, exp_lat0, fin0);
            watch_lane(1, done1, busy1, result1, model_acc1, t, exp_lat1, fin1);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        watch_lane(0, done0, busy0, result0, model_acc0, t, exp_lat0, fin0);
        watch_lane(1, done1, busy1, result1, model_acc1, t, exp_lat1, fin1);
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, done never arrived", cycle_count);
        $display("tb_mac_top: %0d rows, %0d errors", NUM_ROWS, errors);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : stimulus
        errors           = 0;
        seed             = 32'h2bca;
        model_acc0       = '0;
        model_acc1       = '0;
        model_last_lane1 = 1'b1;
        quiet            = 1'b1;
        reset            = 1'b1;
        cmd0_valid       = 1'b0;
        cmd0_op          = mac_pkg::OP_MUL;
        cmd0_a           = 8'd0;
        cmd0_b           = 8'd0;
        cmd1_valid       = 1'b0;
        cmd1_op          = mac_pkg::OP_MUL;
        cmd1_a           = 8'd0;
        cmd1_b           = 8'd0;
        fill_table();
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        // idle outputs and cleared accumulators out of reset.
        watch_lane(0, done0, busy0, result0, model_acc0, 0, 0, quiet);
        watch_lane(1, done1, busy1, result1, model_acc1, 0, 0, quiet);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("tb_mac_top: %0d rows, %0d errors", NUM_ROWS, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/mac_top.sv */
`default_nettype none
`timescale 1ns/100ps

module mac_top #(
    parameter int ACC_WIDTH = 24
) (
    input  wire logic                            clk,
    input  wire logic                            reset,
    input  wire logic                            cmd0_valid,
    input  wire mac_pkg::mac_op_e                cmd0_op,
    input  wire logic [mac_pkg::OPND_WIDTH-1:0]  cmd0_a,
    input  wire logic [mac_pkg::OPND_WIDTH-1:0]  cmd0_b,
    output logic                                 busy0,
    output logic                                 done0,
    output logic      [ACC_WIDTH-1:0]            result0,
    input  wire logic                            cmd1_valid,
    input  wire mac_pkg::mac_op_e                cmd1_op,
    input  wire logic [mac_pkg::OPND_WIDTH-1:0]  cmd1_a,
    input  wire logic [mac_pkg::OPND_WIDTH-1:0]  cmd1_b,
    output logic                                 busy1,
    output logic                                 done1,
    output logic      [ACC_WIDTH-1:0]            result1
);

    logic [mac_pkg::OPND_WIDTH-1:0]  mul_a;
    logic [mac_pkg::OPND_WIDTH-1:0]  mul_b;
    logic [mac_pkg::PROD_WIDTH-1:0]  mul_product;

    mul_port_if lane0_bus ();
    mul_port_if lane1_bus ();

    mac_lane #(
        .ACC_WIDTH (ACC_WIDTH)
    ) u_lane0 (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd0_valid),
        .cmd_op    (cmd0_op),
        .cmd_a     (cmd0_a),
        .cmd_b     (cmd0_b),
        .busy      (busy0),
        .done      (done0),
        .result    (result0),
        .mul       (lane0_bus.lane)
    );

    mac_lane #(
        .ACC_WIDTH (ACC_WIDTH)
    ) u_lane1 (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd1_valid),
        .cmd_op    (cmd1_op),
        .cmd_a     (cmd1_a),
        .cmd_b     (cmd1_b),
        .busy      (busy1),
        .done      (done1),
        .result    (result1),
        .mul       (lane1_bus.lane)
    );

    // single shared multiplier behind the arbiter.
    mul_arbiter u_arbiter (
        .clk         (clk),
        .reset       (reset),
        .lane0       (lane0_bus.arb),
        .lane1       (lane1_bus.arb),
        .mul_a       (mul_a),
        .mul_b       (mul_b),
        .mul_product (mul_product)
    );

    dadda_mul8 u_mul (
        .a       (mul_a),
        .b       (mul_b),
        .product (mul_product)
    );

endmodule

`default_nettype wire

/* rtl/mac_lane.sv */
`default_nettype none
`timescale 1ns/100ps

module mac_lane #(
    parameter int ACC_WIDTH = 24
) (
    input  wire logic                            clk,
    input  wire logic                            reset,
    input  wire logic                            cmd_valid,
    input  wire mac_pkg::mac_op_e                cmd_op,
    input  wire logic [mac_pkg::OPND_WIDTH-1:0]  cmd_a,
    input  wire logic [mac_pkg::OPND_WIDTH-1:0]  cmd_b,
    output logic                                 busy,
    output logic                                 done,
    output logic      [ACC_WIDTH-1:0]            result,
    mul_port_if.lane                             mul
);

    mac_pkg::lane_state_e            state;
    mac_pkg::mac_op_e                op_q;
    logic [mac_pkg::OPND_WIDTH-1:0]  a_q;
    logic [mac_pkg::OPND_WIDTH-1:0]  b_q;
    logic [ACC_WIDTH-1:0]            acc;
    logic [ACC_WIDTH-1:0]            prod_ext;
    logic                            accept;

    // commands are only taken when idle.
    assign accept   = cmd_valid && (state == mac_pkg::LANE_IDLE);
    assign prod_ext = ACC_WIDTH'(mul.product);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mac_pkg::LANE_IDLE;
            acc   <= '0;
        end else begin
            case (state)
                mac_pkg::LANE_IDLE: begin
                    if (accept) begin
                        // clear skips the multiplier.
                        if (cmd_op == mac_pkg::OP_CLR) begin
                            acc   <= '0;
                            state <= mac_pkg::LANE_DONE;
                        end else begin
                            state <= mac_pkg::LANE_REQ;
                        end
                    end
                end
                mac_pkg::LANE_REQ: begin
                    if (mul.product_valid) begin
                        if (op_q == mac_pkg::OP_MAC) begin
                            acc <= acc + prod_ext;
                        end else begin
                            acc <= prod_ext;
                        end
                        state <= mac_pkg::LANE_DONE;
                    end
                end
                default: begin
                    state <= mac_pkg::LANE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= cmd_op;
            a_q  <= cmd_a;
            b_q  <= cmd_b;
        end
    end

    // req drops as soon as the product is back.
    assign mul.req = (state == mac_pkg::LANE_REQ) && !mul.product_valid;
    assign mul.a   = a_q;
    assign mul.b   = b_q;

    assign busy   = (state != mac_pkg::LANE_IDLE);
    assign done   = (state == mac_pkg::LANE_DONE);
    assign result = acc;

    a_no_cmd_busy: assert property (@(posedge clk) disable iff (reset)
        cmd_valid |-> !busy)
        else $error("command issued while lane busy");

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done held longer than one cycle");

endmodule

`default_nettype wire

/* rtl/mul_arbiter.sv */
`default_nettype none
`timescale 1ns/100ps

module mul_arbiter (
    input  wire logic                            clk,
    input  wire logic                            reset,
    mul_port_if.arb                              lane0,
    mul_port_if.arb                              lane1,
    output logic      [mac_pkg::OPND_WIDTH-1:0]  mul_a,
    output logic      [mac_pkg::OPND_WIDTH-1:0]  mul_b,
    input  wire logic [mac_pkg::PROD_WIDTH-1:0]  mul_product
);

    logic                            last_lane1;
    logic                            grant0;
    logic                            grant1;
    logic                            valid0;
    logic                            valid1;
    logic [mac_pkg::PROD_WIDTH-1:0]  product_q;

    // on a tie the lane not served last wins.
    always_comb begin
        grant0 = lane0.req;
        grant1 = lane1.req;
        if (lane0.req && lane1.req) begin
            grant0 = last_lane1;
            grant1 = !last_lane1;
        end
    end

    assign mul_a = grant1 ? lane1.a : lane0.a;
    assign mul_b = grant1 ? lane1.b : lane0.b;

    // starts as if lane 1 went last so lane 0 goes first.
    always_ff @(posedge clk) begin
        if (reset) begin
            last_lane1 <= 1'b1;
            valid0     <= 1'b0;
            valid1     <= 1'b0;
        end else begin
            valid0 <= grant0;
            valid1 <= grant1;
            if (grant0 || grant1) begin
                last_lane1 <= grant1;
            end
        end
    end

    // one product register serves both lanes.
    always_ff @(posedge clk) begin
        if (grant0 || grant1) begin
            product_q <= mul_product;
        end
    end

    assign lane0.grant         = grant0;
    assign lane1.grant         = grant1;
    assign lane0.product       = product_q;
    assign lane1.product       = product_q;
    assign lane0.product_valid = valid0;
    assign lane1.product_valid = valid1;

    a_one_grant: assert property (@(posedge clk) disable iff (reset)
        !(lane0.grant && lane1.grant))
        else $error("both lanes granted");

    a_grant_req: assert property (@(posedge clk) disable iff (reset)
        (!lane0.grant || lane0.req) && (!lane1.grant || lane1.req))
        else $error("grant without request");

    // a lane that loses a tie is served in the next cycle.
    a_tie_lane1_next: assert property (@(posedge clk) disable iff (reset)
        (lane0.grant && lane1.req) |=> lane1.grant)
        else $error("lane 1 not served after losing a tie");

    a_tie_lane0_next: assert property (@(posedge clk) disable iff (reset)
        (lane1.grant && lane0.req) |=> lane0.grant)
        else $error("lane 0 not served after losing a tie");

endmodule

`default_nettype wire

/* rtl/dadda_mul8.sv */
`default_nettype none
`timescale 1ns/100ps

module dadda_mul8 (
    input  wire logic [7:0]  a,
    input  wire logic [7:0]  b,
    output logic      [15:0] product
);

    logic [7:0][7:0] pp;
    logic [42:1]     s;
    logic [42:1]     c;
    logic [13:0]     row_a;
    logic [13:0]     row_b;
    logic [13:0]     row_sum;
    logic            row_cout;

    // row i holds b gated by a[i], bit j has weight i+j.
    for (genvar i = 0; i < 8; i++) begin : g_pp
        assign pp[i] = b & {8{a[i]}};
    end

    // reduce to height 6.
    assign s[1] = pp[0][6] ^ pp[1][5];
    assign c[1] = pp[0][6] & pp[1][5];
    assign s[2] = pp[1][6] ^ pp[2][5] ^ pp[0][7];
    assign c[2] = (pp[1][6] & pp[2][5]) | (pp[1][6] & pp[0][7]) | (pp[2][5] & pp[0][7]);
    assign s[3] = pp[3][4] ^ pp[4][3];
    assign c[3] = pp[3][4] & pp[4][3];
    assign s[4] = pp[2][6] ^ pp[3][5] ^ pp[1][7];
    assign c[4] = (pp[2][6] & pp[3][5]) | (pp[2][6] & pp[1][7]) | (pp[3][5] & pp[1][7]);
    assign s[5] = pp[4][4] ^ pp[5][3];
    assign c[5] = pp[4][4] & pp[5][3];
    assign s[6] = pp[3][6] ^ pp[4][5] ^ pp[2][7];
    assign c[6] = (pp[3][6] & pp[4][5]) | (pp[3][6] & pp[2][7]) | (pp[4][5] & pp[2][7]);

    // reduce to height 4.
    assign s[7]  = pp[0][4] ^ pp[1][3];
    assign c[7]  = pp[0][4] & pp[1][3];
    assign s[8]  = pp[1][4] ^ pp[2][3] ^ pp[0][5];
    assign c[8]  = (pp[1][4] & pp[2][3]) | (pp[1][4] & pp[0][5]) | (pp[2][3] & pp[0][5]);
    assign s[9]  = pp[3][2] ^ pp[4][1];
    assign c[9]  = pp[3][2] & pp[4][1];
    assign s[10] = pp[3][3] ^ pp[4][2] ^ pp[2][4];
    assign c[10] = (pp[3][3] & pp[4][2]) | (pp[3][3] & pp[2][4]) | (pp[4][2] & pp[2][4]);
    assign s[11] = pp[6][0] ^ s[1] ^ pp[5][1];
    assign c[11] = (pp[6][0] & s[1]) | (pp[6][0] & pp[5][1]) | (s[1] & pp[5][1]);
    assign s[12] = pp[6][1] ^ pp[7][0] ^ pp[5][2];
    assign c[12] = (pp[6][1] & pp[7][0]) | (pp[6][1] & pp[5][2]) | (pp[7][0] & pp[5][2]);
    assign s[13] = s[2] ^ s[3] ^ c[1];
    assign c[13] = (s[2] & s[3]) | (s[2] & c[1]) | (s[3] & c[1]);
    assign s[14] = pp[7][1] ^ c[2] ^ pp[6][2];
    assign c[14] = (pp[7][1] & c[2]) | (pp[7][1] & pp[6][2]) | (c[2] & pp[6][2]);
    assign s[15] = s[4] ^ s[5] ^ c[3];
    assign c[15] = (s[4] & s[5]) | (s[4] & c[3]) | (s[5] & c[3]);
    assign s[16] = pp[6][3] ^ pp[7][2] ^ pp[5][4];
    assign c[16] = (pp[6][3] & pp[7][2]) | (pp[6][3] & pp[5][4]) | (pp[7][2] & pp[5][4]);
    assign s[17] = c[5] ^ s[6] ^ c[4];
    assign c[17] = (c[5] & s[6]) | (c[5] & c[4]) | (s[6] & c[4]);
    assign s[18] = pp[4][6] ^ pp[5][5] ^ pp[3][7];
    assign c[18] = (pp[4][6] & pp[5][5]) | (pp[4][6] & pp[3][7]) | (pp[5][5] & pp[3][7]);
    assign s[19] = pp[7][3] ^ c[6] ^ pp[6][4];
    assign c[19] = (pp[7][3] & c[6]) | (pp[7][3] & pp[6][4]) | (c[6] & pp[6][4]);
    assign s[20] = pp[5][6] ^ pp[6][5] ^ pp[4][7];
    assign c[20] = (pp[5][6] & pp[6][5]) | (pp[5][6] & pp[4][7]) | (pp[6][5] & pp[4][7]);

    // reduce to height 3.
    assign s[21] = pp[0][3] ^ pp[1][2];
    assign c[21] = pp[0][3] & pp[1][2];
    assign s[22] = pp[3][1] ^ pp[4][0] ^ pp[2][2];
    assign c[22] = (pp[3][1] & pp[4][0]) | (pp[3][1] & pp[2][2]) | (pp[4][0] & pp[2][2]);
    assign s[23] = c[7] ^ s[8] ^ pp[5][0];
    assign c[23] = (c[7] & s[8]) | (c[7] & pp[5][0]) | (s[8] & pp[5][0]);
    assign s[24] = c[9] ^ s[10] ^ c[8];
    assign c[24] = (c[9] & s[10]) | (c[9] & c[8]) | (s[10] & c[8]);
    assign s[25] = c[11] ^ s[12] ^ c[10];
    assign c[25] = (c[11] & s[12]) | (c[11] & c[10]) | (s[12] & c[10]);
    assign s[26] = c[13] ^ s[14] ^ c[12];
    assign c[26] = (c[13] & s[14]) | (c[13] & c[12]) | (s[14] & c[12]);
    assign s[27] = c[15] ^ s[16] ^ c[14];
    assign c[27] = (c[15] & s[16]) | (c[15] & c[14]) | (s[16] & c[14]);
    assign s[28] = c[17] ^ s[18] ^ c[16];
    assign c[28] = (c[17] & s[18]) | (c[17] & c[16]) | (s[18] & c[16]);
    assign s[29] = c[18] ^ c[19] ^ pp[7][4];
    assign c[29] = (c[18] & c[19]) | (c[18] & pp[7][4]) | (c[19] & pp[7][4]);
    assign s[30] = pp[6][6] ^ pp[7][5] ^ pp[5][7];
    assign c[30] = (pp[6][6] & pp[7][5]) | (pp[6][6] & pp[5][7]) | (pp[7][5] & pp[5][7]);

    // reduce to two rows.
    assign s[31] = pp[0][2] ^ pp[1][1];
    assign c[31] = pp[0][2] & pp[1][1];
    assign s[32] = pp[3][0] ^ s[21] ^ pp[2][1];
    assign c[32] = (pp[3][0] & s[21]) | (pp[3][0] & pp[2][1]) | (s[21] & pp[2][1]);
    assign s[33] = c[21] ^ s[22] ^ s[7];
    assign c[33] = (c[21] & s[22]) | (c[21] & s[7]) | (s[22] & s[7]);
    assign s[34] = c[22] ^ s[23] ^ s[9];
    assign c[34] = (c[22] & s[23]) | (c[22] & s[9]) | (s[23] & s[9]);
    assign s[35] = c[23] ^ s[24] ^ s[11];
    assign c[35] = (c[23] & s[24]) | (c[23] & s[11]) | (s[24] & s[11]);
    assign s[36] = c[24] ^ s[25] ^ s[13];
    assign c[36] = (c[24] & s[25]) | (c[24] & s[13]) | (s[25] & s[13]);
    assign s[37] = c[25] ^ s[26] ^ s[15];
    assign c[37] = (c[25] & s[26]) | (c[25] & s[15]) | (s[26] & s[15]);
    assign s[38] = c[26] ^ s[27] ^ s[17];
    assign c[38] = (c[26] & s[27]) | (c[26] & s[17]) | (s[27] & s[17]);
    assign s[39] = c[27] ^ s[28] ^ s[19];
    assign c[39] = (c[27] & s[28]) | (c[27] & s[19]) | (s[28] & s[19]);
    assign s[40] = c[28] ^ s[29] ^ s[20];
    assign c[40] = (c[28] & s[29]) | (c[28] & s[20]) | (s[29] & s[20]);
    assign s[41] = c[29] ^ s[30] ^ c[20];
    assign c[41] = (c[29] & s[30]) | (c[29] & c[20]) | (s[30] & c[20]);
    assign s[42] = pp[7][6] ^ c[30] ^ pp[6][7];
    assign c[42] = (pp[7][6] & c[30]) | (pp[7][6] & pp[6][7]) | (c[30] & pp[6][7]);

    // bit k of each row carries weight k+1.
    assign row_a = {pp[7][7], c[41:31], pp[2][0], pp[0][1]};
    assign row_b = {c[42], s[42:31], pp[1][0]};

    cla_adder #(
        .WIDTH (14)
    ) u_final_add (
        .a    (row_a),
        .b    (row_b),
        .sum  (row_sum),
        .cout (row_cout)
    );

    assign product = {row_cout, row_sum, pp[0][0]};

endmodule

`default_nettype wire

/* rtl/cla_adder.sv */
`default_nettype none
`timescale 1ns/100ps

module cla_adder #(
    parameter int WIDTH = 14
) (
    input  wire logic [WIDTH-1:0] a,
    input  wire logic [WIDTH-1:0] b,
    output logic      [WIDTH-1:0] sum,
    output logic                  cout
);

    logic [WIDTH-1:0] gen;
    logic [WIDTH-1:0] prop;
    logic [WIDTH:0]   carry;

    // per-bit generate and propagate.
    assign gen  = a & b;
    assign prop = a ^ b;

    // no carry into bit 0.
    assign carry[0] = 1'b0;

    // c[i+1] = g[i] + p[i] * c[i].
    for (genvar i = 0; i < WIDTH; i++) begin : g_carry
        assign carry[i+1] = gen[i] | (prop[i] & carry[i]);
    end

    assign sum  = prop ^ carry[WIDTH-1:0];
    assign cout = carry[WIDTH];

endmodule

`default_nettype wire

/* rtl/mul_port_if.sv */
`default_nettype none
`timescale 1ns/100ps

interface mul_port_if;

    logic                            req;
    logic [mac_pkg::OPND_WIDTH-1:0]  a;
    logic [mac_pkg::OPND_WIDTH-1:0]  b;
    logic                            grant;
    logic [mac_pkg::PROD_WIDTH-1:0]  product;
    logic                            product_valid;

    // lane side requests and holds operands.
    modport lane (output req, output a, output b,
                  input grant, input product, input product_valid);

    // arbiter side grants and returns the registered product.
    modport arb (input req, input a, input b,
                 output grant, output product, output product_valid);

endinterface

`default_nettype wire

/* rtl/mac_pkg.sv */
`default_nettype none

package mac_pkg;

    // operand width is fixed by the 8x8 multiplier tree.
    localparam int OPND_WIDTH = 8;

    // full unsigned product of two operands.
    localparam int PROD_WIDTH = 16;

    // lane command opcodes.
    typedef enum logic [1:0] {
        OP_MUL = 2'd0,
        OP_MAC = 2'd1,
        OP_CLR = 2'd2
    } mac_op_e;

    // lane control states.
    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_REQ  = 2'd1,
        LANE_DONE = 2'd2
    } lane_state_e;

endpackage

`default_nettype wire
